//--- bench/alu_pipeline_sva.sv
// ALU lane handshake assertions
`timescale 1ns/1ps
`default_nettype none

module alu_pipeline_sva
   import alu_pkg::*;
(
   input wire       clk,
   input wire       i_rst,
   input wire       i_flush,
   input wire       i_wb_ready,
   input wire       i_wb_valid,
   input alu_data_t i_wb_data,
   input rob_id_t   i_wb_id,
   input wire [2:0] i_wb_flags,
   input wire       i_issue_valid,
   input wire       i_issue_ready,
   input wire       i_iq_pop
);

   logic [2:0] iq_cnt;   // Queue occupancy seen from the handshakes

   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
         iq_cnt <= '0;
      else
         iq_cnt <= iq_cnt + {2'b0, i_issue_valid & i_issue_ready} - {2'b0, i_iq_pop};
   end

   // No results while in reset
   a_rst_quiet: assert property (@(posedge clk) i_rst |=> !i_wb_valid)
      else $error("o_wb_valid high during reset");

   // Stalled writeback holds
   a_wb_hold: assert property (@(posedge clk) disable iff (i_rst || i_flush)
      (i_wb_valid && !i_wb_ready) |=> (i_wb_valid && $stable({i_wb_data, i_wb_id, i_wb_flags})))
      else $error("writeback outputs changed under back-pressure");

   // Room left in the queue keeps dispatch open
   a_free_slot: assert property (@(posedge clk) disable iff (i_rst)
      (iq_cnt < 3'(IQ_DEPTH)) |-> i_issue_ready)
      else $error("o_issue_ready low with a free queue entry");

endmodule

bind alu_pipeline alu_pipeline_sva u_sva
(
   .clk           (clk),
   .i_rst         (i_rst),
   .i_flush       (i_flush),
   .i_wb_ready    (i_wb_ready),
   .i_wb_valid    (o_wb_valid),
   .i_wb_data     (o_wb_data),
   .i_wb_id       (o_wb_id),
   .i_wb_flags    ({o_wb_branch_op, o_wb_rel_taken, o_wb_reg_taken}),
   .i_issue_valid (i_issue_valid),
   .i_issue_ready (o_issue_ready),
   .i_iq_pop      (iq_valid & decode_ready)
);

`default_nettype wire

//--- bench/tb_alu_pipeline.sv
// ALU lane random testbench
`timescale 1ns/1ps
`default_nettype none

module tb_alu_pipeline
   import alu_pkg::*;
;
   localparam int N_OPS = 400;             // Planned micro-ops

   logic clk = 1'b0;
   logic      i_rst;
   logic      i_flush;
   logic      i_issue_valid;
   logic      o_issue_ready;
   alu_uop_t  i_issue_uop;
   rob_id_t   i_issue_id;
   logic      i_rs1_rdy;
   logic      i_rs2_rdy;
   logic      i_byp_valid;
   logic      i_wb_ready;
   alu_data_t i_rs1_dat;
   alu_data_t i_rs2_dat;
   alu_data_t i_byp_data;
   reg_addr_t i_rs1_addr;
   reg_addr_t i_rs2_addr;
   reg_addr_t i_byp_addr;
   logic      o_wb_valid;
   logic      o_wb_branch_op;
   logic      o_wb_rel_taken;
   logic      o_wb_reg_taken;
   alu_data_t o_wb_data;
   rob_id_t   o_wb_id;

   // Register table where pending regs wait for a scheduled bypass
   alu_data_t reg_val [32];
   logic      reg_pend [32];
   int        byp_cyc [32];
   // Scoreboard by id
   logic      sb_vld [16];
   alu_data_t sb_data [16];
   logic [2:0] sb_flags [16];
   // Offer held on the issue port
   logic       off_valid;
   logic [3:0] off_opc;
   logic [REL_W-1:0] off_rel;
   reg_addr_t  off_a1;
   reg_addr_t  off_a2;
   rob_id_t    off_id;
   rob_id_t    next_id;
   logic [31:0] seed = 32'hc4a1;
   int cyc;
   int issued;
   int outstanding;
   int byp_r;
   logic byp_hit;

   always #50 clk = ~clk;

   alu_pipeline u_dut (.*);

   function automatic logic [31:0] next_rand();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   // Rule table with flags {branch_op, rel_taken, reg_taken}
   function automatic void ref_alu(input logic [3:0] opc, input logic [REL_W-1:0] rel,
                                   input alu_data_t a, input alu_data_t b,
                                   output alu_data_t d, output logic [2:0] f);
      f = 3'b000;
      case (alu_opc_e'(opc))
         OPC_ADD:  d = a + b;
         OPC_SUB:  d = a - b;
         OPC_AND:  d = a & b;
         OPC_OR:   d = a | b;
         OPC_XOR:  d = a ^ b;
         OPC_SLL:  d = a << b[4:0];
         OPC_SRL:  d = a >> b[4:0];
         OPC_SRA:  d = $unsigned($signed(a) >>> b[4:0]);
         OPC_SLT:  d = {31'b0, $signed(a) < $signed(b)};
         OPC_SLTU: d = {31'b0, a < b};
         OPC_BEQ:
         begin
            d = alu_data_t'($signed(rel));
            f = {1'b1, a == b, 1'b0};
         end
         OPC_BNE:
         begin
            d = alu_data_t'($signed(rel));
            f = {1'b1, a != b, 1'b0};
         end
         OPC_JR:
         begin
            d = a;
            f = 3'b101;
         end
         default:  d = '0;                 // NOP and unused codes
      endcase
   endfunction

   task automatic stop_run();
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input alu_data_t exp, input alu_data_t act);
      if (exp !== act)
      begin
         $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_id(input string name, input rob_id_t exp, input rob_id_t act);
      if (exp !== act)
      begin
         $display("Error at %0t: %s expected %0d actual %0d", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_flags(input string name, input logic [2:0] exp, input logic [2:0] act);
      if (exp !== act)
      begin
         $display("Error at %0t: %s expected %b actual %b", $time, name, exp, act);
         stop_run();
      end
   endtask

   task automatic check_result();
      rob_id_t id;
      rob_id_t lone;
      id   = o_wb_id;
      lone = '0;
      if (outstanding == 1)
      begin
         foreach (sb_vld[k])
         begin
            if (sb_vld[k])
               lone = rob_id_t'(k);
         end
         check_id("o_wb_id", lone, o_wb_id);  // Only one op in flight
      end
      if (!sb_vld[id])
      begin
         $display("Result for id %0d arrived with no outstanding operation", id);
         stop_run();
      end
      check_data("o_wb_data", sb_data[id], o_wb_data);
      check_flags("o_wb_flags", sb_flags[id], {o_wb_branch_op, o_wb_rel_taken, o_wb_reg_taken});
      sb_vld[id] = 1'b0;
      outstanding--;
   endtask

   // Picks a source register and sometimes makes it pending
   function automatic reg_addr_t pick_src();
      reg_addr_t a;
      a = reg_addr_t'(next_rand());
      if (!reg_pend[a] && (next_rand() % 3 == 0))
      begin
         reg_val[a]  = next_rand();
         reg_pend[a] = 1'b1;
         byp_cyc[a]  = cyc + int'(next_rand() % 8);  // Strobe one cycle later at the earliest
      end
      return a;
   endfunction

   task automatic make_offer();
      off_opc = 4'(next_rand());
      off_rel = REL_W'(next_rand());
      off_a1  = pick_src();
      off_a2  = (next_rand() % 4 == 0) ? off_a1 : pick_src();  // Equal operands for branches
      off_id  = next_id;
      next_id++;
      issued++;
      off_valid = 1'b1;
   endtask

   task automatic accept_offer();
      alu_data_t d;
      logic [2:0] f;
      ref_alu(off_opc, off_rel, reg_val[off_a1], reg_val[off_a2], d, f);
      sb_vld[off_id]   = 1'b1;
      sb_data[off_id]  = d;
      sb_flags[off_id] = f;
      outstanding++;
      off_valid = 1'b0;
   endtask

   always @(posedge clk)
   begin
      if (!i_rst)
      begin
         cyc++;
         if (o_wb_valid && i_wb_ready)
            check_result();
         if (i_flush)
         begin
            foreach (sb_vld[k])
               sb_vld[k] = 1'b0;           // Old ids never return
            outstanding = 0;
            off_valid   = 1'b0;
         end
         else if (i_issue_valid && o_issue_ready)
            accept_offer();
         byp_hit = 1'b0;
         for (int r = 0; r < 32; r++)
         begin
            if (!byp_hit && reg_pend[r] && byp_cyc[r] <= cyc)
            begin
               byp_hit = 1'b1;
               byp_r   = r;
            end
         end
         if (!off_valid && issued < N_OPS && !sb_vld[next_id] && (next_rand() % 4 != 0))
            make_offer();
         i_issue_valid <= off_valid;
         i_issue_uop   <= {off_rel, off_opc};
         i_issue_id    <= off_id;
         i_rs1_addr    <= off_a1;
         i_rs2_addr    <= off_a2;
         i_rs1_rdy     <= !reg_pend[off_a1];  // Pending until its strobe is past
         i_rs2_rdy     <= !reg_pend[off_a2];
         i_rs1_dat     <= reg_val[off_a1];
         i_rs2_dat     <= reg_val[off_a2];
         i_byp_valid   <= byp_hit;
         i_byp_addr    <= reg_addr_t'(byp_r);
         i_byp_data    <= reg_val[byp_r];
         if (byp_hit)
            reg_pend[byp_r] = 1'b0;
         i_wb_ready <= (next_rand() % 4 != 0);
         i_flush    <= (issued > 0) && (issued < N_OPS) && (next_rand() % 97 == 0);
      end
   end

   // Watchdog
   initial
   begin
      #(N_OPS * 40 * 100);
      $display("Timeout, the pipeline did not drain in time");
      stop_run();
   end

   initial
   begin
      int left;
      i_rst = 1'b1;
      i_flush = 1'b0;
      i_issue_valid = 1'b0;
      i_issue_uop = '0;
      i_issue_id = '0;
      i_rs1_rdy = 1'b0;
      i_rs2_rdy = 1'b0;
      i_rs1_dat = '0;
      i_rs2_dat = '0;
      i_rs1_addr = '0;
      i_rs2_addr = '0;
      i_byp_valid = 1'b0;
      i_byp_data = '0;
      i_byp_addr = '0;
      i_wb_ready = 1'b0;
      off_valid = 1'b0;
      next_id = '0;
      cyc = 0;
      issued = 0;
      outstanding = 0;
      byp_r = 0;
      for (int r = 0; r < 32; r++)
      begin
         reg_val[r]  = next_rand();
         reg_pend[r] = 1'b0;
         byp_cyc[r]  = 0;
      end
      foreach (sb_vld[k])
         sb_vld[k] = 1'b0;
      repeat (16) @(posedge clk);
      i_rst <= 1'b0;
      while (!(issued == N_OPS && !off_valid && outstanding == 0))
         @(posedge clk);
      repeat (20) @(posedge clk);         // Catch late duplicates
      left = 0;
      foreach (sb_vld[k])
         left += int'(sb_vld[k]);
      if (left == 0)
      begin
         $display("TB PASSED");
         $finish;
      end
      else
      begin
         $display("Scoreboard still holds %0d entries after drain", left);
         stop_run();
      end
   end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the ALU lane testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_alu_pipeline -f src.f
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_alu_pipeline)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
   exit 0
fi
exit 1

//--- source/alu_execute.sv
// ALU execute stage
`timescale 1ns/1ps
`default_nettype none

module alu_execute
   import alu_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst,
   input  wire          i_flush,
   input  wire          i_valid,
   output logic         o_ready,
   input  alu_opc_bus_t i_opc_bus,
   input  alu_data_t    i_rel,
   input  rob_id_t      i_id,
   input  alu_data_t    i_op1,
   input  alu_data_t    i_op2,
   input  wire          i_ready,
   output logic         o_valid,
   output alu_data_t    o_data,
   output rob_id_t      o_id,
   output logic         o_branch_op,
   output logic         o_rel_taken,
   output logic         o_reg_taken
);

   alu_data_t  sum;
   alu_data_t  dif;
   alu_data_t  sll;
   alu_data_t  srl;
   alu_data_t  sra;
   alu_data_t  res;
   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;
   logic       eq;
   logic       is_beq;
   logic       is_bne;
   logic       is_jr;
   logic       accept;

   // Functional units
   assign sum   = i_op1 + i_op2;            // Wraps at 32 bits
   assign dif   = i_op1 - i_op2;
   assign shamt = i_op2[4:0];
   assign sll   = i_op1 << shamt;
   assign srl   = i_op1 >> shamt;
   assign sra   = alu_data_t'($signed(i_op1) >>> shamt);
   assign lt_s  = $signed(i_op1) < $signed(i_op2);
   assign lt_u  = i_op1 < i_op2;
   assign eq    = i_op1 == i_op2;

   assign is_beq = i_opc_bus[OPC_BEQ-1];
   assign is_bne = i_opc_bus[OPC_BNE-1];
   assign is_jr  = i_opc_bus[OPC_JR-1];

   // One-hot result select, empty bus gives zero
   assign res = ({ALU_DW{i_opc_bus[OPC_ADD-1]}}  & sum)
              | ({ALU_DW{i_opc_bus[OPC_SUB-1]}}  & dif)
              | ({ALU_DW{i_opc_bus[OPC_AND-1]}}  & (i_op1 & i_op2))
              | ({ALU_DW{i_opc_bus[OPC_OR-1]}}   & (i_op1 | i_op2))
              | ({ALU_DW{i_opc_bus[OPC_XOR-1]}}  & (i_op1 ^ i_op2))
              | ({ALU_DW{i_opc_bus[OPC_SLL-1]}}  & sll)
              | ({ALU_DW{i_opc_bus[OPC_SRL-1]}}  & srl)
              | ({ALU_DW{i_opc_bus[OPC_SRA-1]}}  & sra)
              | ({ALU_DW{i_opc_bus[OPC_SLT-1]}}  & {{(ALU_DW-1){1'b0}}, lt_s})
              | ({ALU_DW{i_opc_bus[OPC_SLTU-1]}} & {{(ALU_DW-1){1'b0}}, lt_u})
              | ({ALU_DW{is_beq | is_bne}}       & i_rel)   // Branch target offset
              | ({ALU_DW{is_jr}}                 & i_op1);  // Jump target register

   assign o_ready = ~o_valid | i_ready;
   assign accept  = i_valid & o_ready;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
         o_valid <= 1'b0;
      else if (o_ready)
         o_valid <= i_valid;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         o_data      <= res;
         o_id        <= i_id;
         o_branch_op <= is_beq | is_bne | is_jr;
         o_rel_taken <= (is_beq & eq) | (is_bne & ~eq);
         o_reg_taken <= is_jr;             // JR always taken
      end
   end

endmodule

`default_nettype wire

//--- source/alu_issue_queue.sv
// ALU out-of-order issue queue
`timescale 1ns/1ps
`default_nettype none

module alu_issue_queue
   import alu_pkg::*;
(
   input  wire       clk,
   input  wire       i_rst,
   input  wire       i_flush,
   // Dispatch side
   input  wire       i_issue_valid,
   output logic      o_issue_ready,
   input  alu_uop_t  i_issue_uop,
   input  rob_id_t   i_issue_id,
   input  wire       i_rs1_rdy,
   input  wire       i_rs2_rdy,
   input  alu_data_t i_rs1_dat,
   input  alu_data_t i_rs2_dat,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   // Bypass broadcast
   input  wire       i_byp_valid,
   input  alu_data_t i_byp_data,
   input  reg_addr_t i_byp_addr,
   // Toward decode
   input  wire       i_fu_ready,
   output logic      o_fu_valid,
   output alu_uop_t  o_fu_uop,
   output rob_id_t   o_fu_id,
   output alu_data_t o_fu_op1,
   output alu_data_t o_fu_op2
);

   logic [IQ_DEPTH-1:0] ent_valid;     // Entry occupied
   logic [IQ_DEPTH-1:0] ent_rdy1;      // rs1 known
   logic [IQ_DEPTH-1:0] ent_rdy2;      // rs2 known
   logic [IQ_DEPTH-1:0] ent_ready;     // Both known, may be selected
   logic [IQ_DEPTH-1:0] wake1;
   logic [IQ_DEPTH-1:0] wake2;

   alu_uop_t  ent_uop   [IQ_DEPTH];
   rob_id_t   ent_id    [IQ_DEPTH];
   alu_data_t ent_dat1  [IQ_DEPTH];
   alu_data_t ent_dat2  [IQ_DEPTH];
   reg_addr_t ent_addr1 [IQ_DEPTH];
   reg_addr_t ent_addr2 [IQ_DEPTH];

   logic [IQ_IW-1:0] wr_idx;           // Lowest free slot
   logic [IQ_IW-1:0] sel_idx;          // Lowest ready slot
   logic             iss_fire;
   logic             fu_fire;
   logic             in_rdy1;
   logic             in_rdy2;
   alu_data_t        in_dat1;
   alu_data_t        in_dat2;

   // Bypass hit on the incoming uop, same edge
   assign in_rdy1 = i_rs1_rdy | (i_byp_valid & (i_byp_addr == i_rs1_addr));
   assign in_rdy2 = i_rs2_rdy | (i_byp_valid & (i_byp_addr == i_rs2_addr));
   assign in_dat1 = i_rs1_rdy ? i_rs1_dat : i_byp_data;
   assign in_dat2 = i_rs2_rdy ? i_rs2_dat : i_byp_data;

   assign o_issue_ready = ~&ent_valid;  // Any free slot
   assign iss_fire      = i_issue_valid & o_issue_ready;
   assign fu_fire       = o_fu_valid & i_fu_ready;

   assign ent_ready = ent_valid & ent_rdy1 & ent_rdy2;
   assign o_fu_valid = |ent_ready;

   always_comb
   begin
      wr_idx  = '0;
      sel_idx = '0;
      wake1   = '0;
      wake2   = '0;
      // Downward scan leaves the lowest index
      for (int k = IQ_DEPTH - 1; k >= 0; k--)
      begin
         if (!ent_valid[k])
            wr_idx = IQ_IW'(k);
         if (ent_ready[k])
            sel_idx = IQ_IW'(k);
      end
      for (int k = 0; k < IQ_DEPTH; k++)
      begin
         wake1[k] = ent_valid[k] & ~ent_rdy1[k] & i_byp_valid & (ent_addr1[k] == i_byp_addr);
         wake2[k] = ent_valid[k] & ~ent_rdy2[k] & i_byp_valid & (ent_addr2[k] == i_byp_addr);
      end
   end

   // Occupancy and readiness
   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
      begin
         ent_valid <= '0;
         ent_rdy1  <= '0;
         ent_rdy2  <= '0;
      end
      else
      begin
         for (int k = 0; k < IQ_DEPTH; k++)
         begin
            if (iss_fire && (wr_idx == IQ_IW'(k)))
            begin
               ent_valid[k] <= 1'b1;
               ent_rdy1[k]  <= in_rdy1;
               ent_rdy2[k]  <= in_rdy2;
            end
            else
            begin
               if (fu_fire && (sel_idx == IQ_IW'(k)))
                  ent_valid[k] <= 1'b0;   // Leaves toward decode
               if (wake1[k])
                  ent_rdy1[k] <= 1'b1;
               if (wake2[k])
                  ent_rdy2[k] <= 1'b1;
            end
         end
      end
   end

   // Payload, no reset
   always_ff @(posedge clk)
   begin
      for (int k = 0; k < IQ_DEPTH; k++)
      begin
         if (iss_fire && (wr_idx == IQ_IW'(k)))
         begin
            ent_uop[k]   <= i_issue_uop;
            ent_id[k]    <= i_issue_id;
            ent_dat1[k]  <= in_dat1;
            ent_dat2[k]  <= in_dat2;
            ent_addr1[k] <= i_rs1_addr;
            ent_addr2[k] <= i_rs2_addr;
         end
         else
         begin
            if (wake1[k])
               ent_dat1[k] <= i_byp_data;  // Late operand capture
            if (wake2[k])
               ent_dat2[k] <= i_byp_data;
         end
      end
   end

   assign o_fu_uop = ent_uop[sel_idx];
   assign o_fu_id  = ent_id[sel_idx];
   assign o_fu_op1 = ent_dat1[sel_idx];
   assign o_fu_op2 = ent_dat2[sel_idx];

endmodule

`default_nettype wire

//--- source/alu_pipeline.sv
// ALU lane top level
`timescale 1ns/1ps
`default_nettype none

module alu_pipeline
   import alu_pkg::*;
(
   input  wire       clk,
   input  wire       i_rst,
   input  wire       i_flush,
   // Issue from dispatch
   input  wire       i_issue_valid,
   output logic      o_issue_ready,
   input  alu_uop_t  i_issue_uop,
   input  rob_id_t   i_issue_id,
   input  wire       i_rs1_rdy,
   input  alu_data_t i_rs1_dat,
   input  reg_addr_t i_rs1_addr,
   input  wire       i_rs2_rdy,
   input  alu_data_t i_rs2_dat,
   input  reg_addr_t i_rs2_addr,
   // Bypass strobe
   input  wire       i_byp_valid,
   input  alu_data_t i_byp_data,
   input  reg_addr_t i_byp_addr,
   // Writeback
   input  wire       i_wb_ready,
   output logic      o_wb_valid,
   output alu_data_t o_wb_data,
   output rob_id_t   o_wb_id,
   output logic      o_wb_branch_op,
   output logic      o_wb_rel_taken,
   output logic      o_wb_reg_taken
);

   // Queue -> decode
   logic         iq_valid;
   logic         decode_ready;
   alu_uop_t     iq_uop;
   rob_id_t      iq_id;
   alu_data_t    iq_op1;
   alu_data_t    iq_op2;
   // Decode -> execute
   logic         dec_valid;
   logic         exec_ready;
   alu_opc_bus_t dec_opc_bus;
   alu_data_t    dec_rel;
   rob_id_t      dec_id;
   alu_data_t    dec_op1;
   alu_data_t    dec_op2;
   // Execute -> result buffer
   logic         ex_valid;
   logic         buf_ready;
   alu_data_t    ex_data;
   rob_id_t      ex_id;
   logic         ex_branch_op;
   logic         ex_rel_taken;
   logic         ex_reg_taken;

   alu_issue_queue u_iq
   (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_flush       (i_flush),
      .i_issue_valid (i_issue_valid),
      .o_issue_ready (o_issue_ready),
      .i_issue_uop   (i_issue_uop),
      .i_issue_id    (i_issue_id),
      .i_rs1_rdy     (i_rs1_rdy),
      .i_rs2_rdy     (i_rs2_rdy),
      .i_rs1_dat     (i_rs1_dat),
      .i_rs2_dat     (i_rs2_dat),
      .i_rs1_addr    (i_rs1_addr),
      .i_rs2_addr    (i_rs2_addr),
      .i_byp_valid   (i_byp_valid),
      .i_byp_data    (i_byp_data),
      .i_byp_addr    (i_byp_addr),
      .i_fu_ready    (decode_ready),
      .o_fu_valid    (iq_valid),
      .o_fu_uop      (iq_uop),
      .o_fu_id       (iq_id),
      .o_fu_op1      (iq_op1),
      .o_fu_op2      (iq_op2)
   );

   alu_uop_decode u_dec
   (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_flush   (i_flush),
      .i_valid   (iq_valid),
      .o_ready   (decode_ready),
      .i_uop     (iq_uop),
      .i_id      (iq_id),
      .i_op1     (iq_op1),
      .i_op2     (iq_op2),
      .i_ready   (exec_ready),
      .o_valid   (dec_valid),
      .o_opc_bus (dec_opc_bus),
      .o_rel     (dec_rel),
      .o_id      (dec_id),
      .o_op1     (dec_op1),
      .o_op2     (dec_op2)
   );

   alu_execute u_exe
   (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_flush     (i_flush),
      .i_valid     (dec_valid),
      .o_ready     (exec_ready),
      .i_opc_bus   (dec_opc_bus),
      .i_rel       (dec_rel),
      .i_id        (dec_id),
      .i_op1       (dec_op1),
      .i_op2       (dec_op2),
      .i_ready     (buf_ready),
      .o_valid     (ex_valid),
      .o_data      (ex_data),
      .o_id        (ex_id),
      .o_branch_op (ex_branch_op),
      .o_rel_taken (ex_rel_taken),
      .o_reg_taken (ex_reg_taken)
   );

   alu_result_buf u_rbuf
   (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_flush        (i_flush),
      .i_valid        (ex_valid),
      .o_ready        (buf_ready),
      .i_data         (ex_data),
      .i_id           (ex_id),
      .i_branch_op    (ex_branch_op),
      .i_rel_taken    (ex_rel_taken),
      .i_reg_taken    (ex_reg_taken),
      .i_wb_ready     (i_wb_ready),
      .o_wb_valid     (o_wb_valid),
      .o_wb_data      (o_wb_data),
      .o_wb_id        (o_wb_id),
      .o_wb_branch_op (o_wb_branch_op),
      .o_wb_rel_taken (o_wb_rel_taken),
      .o_wb_reg_taken (o_wb_reg_taken)
   );

endmodule

`default_nettype wire

//--- source/alu_pkg.sv
// ALU lane shared definitions
`default_nettype none

package alu_pkg;

   // Datapath widths
   localparam int ALU_DW   = 32;          // Operand / result width
   localparam int REG_AW   = 5;           // Architectural register address
   localparam int ROB_AW   = 4;           // Reorder buffer id

   // Issue queue geometry
   localparam int IQ_DEPTH = 4;
   localparam int IQ_IW    = $clog2(IQ_DEPTH); // Entry index width

   // Micro-op layout, {rel, opc}
   localparam int OPC_W    = 4;
   localparam int REL_W    = 15;
   localparam int UOP_W    = REL_W + OPC_W; // 19 bits total

   // One-hot op bus, bit k-1 <-> opcode k
   localparam int ALU_IOPW = 13;

   typedef logic [ALU_DW-1:0]   alu_data_t;
   typedef logic [REG_AW-1:0]   reg_addr_t;
   typedef logic [ROB_AW-1:0]   rob_id_t;
   typedef logic [UOP_W-1:0]    alu_uop_t;
   typedef logic [ALU_IOPW-1:0] alu_opc_bus_t;

   // Opcodes, NOP has no bus bit
   typedef enum logic [OPC_W-1:0]
   {
      OPC_NOP  = 4'd0,
      OPC_ADD  = 4'd1,
      OPC_SUB  = 4'd2,
      OPC_AND  = 4'd3,
      OPC_OR   = 4'd4,
      OPC_XOR  = 4'd5,
      OPC_SLL  = 4'd6,   // Shift amount from B[4:0]
      OPC_SRL  = 4'd7,
      OPC_SRA  = 4'd8,
      OPC_SLT  = 4'd9,   // Signed compare
      OPC_SLTU = 4'd10,  // Unsigned compare
      OPC_BEQ  = 4'd11,  // Relative branch, taken on A==B
      OPC_BNE  = 4'd12,  // Relative branch, taken on A!=B
      OPC_JR   = 4'd13   // Register jump, always taken
   } alu_opc_e;

   // Codes 14 and 15 unused
   // Decode maps them to an empty bus

endpackage

`default_nettype wire

//--- source/alu_result_buf.sv
// ALU writeback result FIFO
`timescale 1ns/1ps
`default_nettype none

module alu_result_buf
   import alu_pkg::*;
(
   input  wire       clk,
   input  wire       i_rst,
   input  wire       i_flush,
   input  wire       i_valid,
   output logic      o_ready,
   input  alu_data_t i_data,
   input  rob_id_t   i_id,
   input  wire       i_branch_op,
   input  wire       i_rel_taken,
   input  wire       i_reg_taken,
   input  wire       i_wb_ready,
   output logic      o_wb_valid,
   output alu_data_t o_wb_data,
   output rob_id_t   o_wb_id,
   output logic      o_wb_branch_op,
   output logic      o_wb_rel_taken,
   output logic      o_wb_reg_taken
);

   // Entry layout {data, id, branch_op, rel_taken, reg_taken}
   logic [ALU_DW+ROB_AW+2:0] mem [2];
   logic                     wr_ptr;
   logic                     rd_ptr;
   logic [1:0]               count;
   logic                     push;
   logic                     pop;

   assign o_ready    = (count != 2'd2);
   assign o_wb_valid = (count != 2'd0);
   assign push       = i_valid & o_ready;
   assign pop        = o_wb_valid & i_wb_ready;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         count <= count + {1'b0, push} - {1'b0, pop};  // Net occupancy change
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= {i_data, i_id, i_branch_op, i_rel_taken, i_reg_taken};
   end

   // Head entry drives writeback, holds until popped
   assign {o_wb_data, o_wb_id, o_wb_branch_op, o_wb_rel_taken, o_wb_reg_taken} = mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/alu_uop_decode.sv
// ALU micro-op decode stage
`timescale 1ns/1ps
`default_nettype none

module alu_uop_decode
   import alu_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst,
   input  wire          i_flush,
   input  wire          i_valid,
   output logic         o_ready,
   input  alu_uop_t     i_uop,
   input  rob_id_t      i_id,
   input  alu_data_t    i_op1,
   input  alu_data_t    i_op2,
   input  wire          i_ready,
   output logic         o_valid,
   output alu_opc_bus_t o_opc_bus,
   output alu_data_t    o_rel,
   output rob_id_t      o_id,
   output alu_data_t    o_op1,
   output alu_data_t    o_op2
);

   alu_opc_e         opc;
   logic [REL_W-1:0] rel;
   alu_opc_bus_t     opc_bus;
   logic             accept;

   assign {rel, opc} = {i_uop[UOP_W-1:OPC_W], alu_opc_e'(i_uop[OPC_W-1:0])};

   always_comb
   begin
      opc_bus = '0;
      for (int k = 1; k <= ALU_IOPW; k++)
         opc_bus[k-1] = (opc == alu_opc_e'(k));  // Codes 14/15 match nothing
   end

   assign o_ready = ~o_valid | i_ready;   // Empty or draining
   assign accept  = i_valid & o_ready;

   always_ff @(posedge clk)
   begin
      if (i_rst || i_flush)
         o_valid <= 1'b0;
      else if (o_ready)
         o_valid <= i_valid;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         o_opc_bus <= opc_bus;
         o_rel     <= {{(ALU_DW-REL_W){rel[REL_W-1]}}, rel};  // Sign extend
         o_id      <= i_id;
         o_op1     <= i_op1;
         o_op2     <= i_op2;
      end
   end

endmodule

`default_nettype wire

//--- src.f
source/alu_pkg.sv
source/alu_issue_queue.sv
source/alu_uop_decode.sv
source/alu_execute.sv
source/alu_result_buf.sv
source/alu_pipeline.sv
bench/alu_pipeline_sva.sv
bench/tb_alu_pipeline.sv
